/* logic/ack_timer.sv */
////////////////////////////////////////
// ack wait counter, flags a timeout
////////////////////////////////////////

`timescale 1ns/1ns

module ack_timer (
  input  logic clk,
  input  logic reset_i,
  input  logic start_i,    // pulse with the strobe
  input  logic stop_i,     // pulse on ack
  output logic timeout_o   // one cycle pulse
);

  import ps_bus_pkg::*;

  logic [TMR_W-1:0] cnt;    // cycles left
  logic             armed;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      armed <= 1'b0;
      cnt   <= '0;
    end else if (stop_i) begin
      armed <= 1'b0;        // ack arrived in time
      cnt   <= '0;
    end else if (start_i) begin
      armed <= 1'b1;
      cnt   <= TMR_W'(ACK_TIMEOUT);
    end else if (armed) begin
      if (cnt == '0) begin
        armed <= 1'b0;      // expired, disarm after the pulse
      end else begin
        cnt <= cnt - 1'b1;
      end
    end
  end

  // high for the single cycle the armed count sits at zero
  assign timeout_o = armed && (cnt == '0);

endmodule

/* logic/apb_sys_fsm.sv */
////////////////////////////////////////
// apb completer sequencing fsm
// idle -> strobe -> wait -> done
////////////////////////////////////////

`timescale 1ns/1ns

module apb_sys_fsm (
  input  logic clk,
  input  logic reset_i,
  // apb control
  input  logic psel_i,
  input  logic penable_i,
  input  logic pwrite_i,
  // system bus response
  input  logic sys_ack_i,
  input  logic sys_err_i,
  input  logic timeout_i,       // from ack_timer
  // to latch
  output logic capture_o,
  // system bus strobes
  output logic sys_wen_o,
  output logic sys_ren_o,
  // timer control
  output logic timer_start_o,
  output logic timer_stop_o,
  // apb response
  output logic pready_o,
  output logic pslverr_o
);

  import ps_bus_pkg::*;

  logic [ST_W-1:0] state;
  logic            access;  // first access cycle seen in idle
  logic            resp;    // slave answered or gave up

  ////////////////////////////////////////
  // decode
  ////////////////////////////////////////

  // setup cycle has penable low, so this fires once per transfer
  assign access = (state == ST_IDLE) && psel_i && penable_i;
  assign resp   = (state == ST_WAIT) && (sys_ack_i || timeout_i);

  assign capture_o    = access;                          // latch takes request now
  assign timer_stop_o = (state == ST_WAIT) && sys_ack_i; // ack beats the timer

  ////////////////////////////////////////
  // state and registered outputs
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      state         <= ST_IDLE;
      sys_wen_o     <= 1'b0;
      sys_ren_o     <= 1'b0;
      timer_start_o <= 1'b0;
      pready_o      <= 1'b0;
      pslverr_o     <= 1'b0;
    end else begin
      // pulses default low
      sys_wen_o     <= 1'b0;
      sys_ren_o     <= 1'b0;
      timer_start_o <= 1'b0;
      pready_o      <= 1'b0;

      case (state)
        ST_IDLE: begin
          if (access) begin
            state         <= ST_STROBE;
            // strobe is high for the whole strobe state
            sys_wen_o     <= pwrite_i;
            sys_ren_o     <= !pwrite_i;
            timer_start_o <= 1'b1;   // arm timer with the strobe
          end
        end

        ST_STROBE: begin
          state <= ST_WAIT;          // slave sees strobe this cycle
        end

        ST_WAIT: begin
          if (resp) begin
            state     <= ST_DONE;
            pready_o  <= 1'b1;       // one cycle after ack / timeout
            // unmapped region never acks, timeout is always an error
            pslverr_o <= timeout_i ? 1'b1 : sys_err_i;
          end
        end

        ST_DONE: begin
          state     <= ST_IDLE;      // host samples pready here
          pslverr_o <= 1'b0;
        end

        default: begin
          state <= ST_IDLE;
        end
      endcase
    end
  end

endmodule

/* logic/ps_bus_pkg.sv */
////////////////////////////////////////
// system bus widths and region codes
// fsm state codes, ack timeout, id word
// system address union (flat / fields)
////////////////////////////////////////

package ps_bus_pkg;

  // bus widths
  localparam int SYS_AW   = 32;            // address, apb and system side
  localparam int SYS_DW   = 32;            // data
  localparam int SYS_SW   = SYS_DW / 8;    // byte selects
  localparam int REGION_W = 4;             // addr[23:20]
  localparam int OFFSET_W = 20;            // addr[19:0]
  localparam int TOP_W    = SYS_AW - REGION_W - OFFSET_W;  // addr[31:24], not decoded

  // region map
  localparam logic [REGION_W-1:0] REGION_REGS = 4'd0;  // register file
  localparam logic [REGION_W-1:0] REGION_ID   = 4'd1;  // id word, read only

  // register file
  localparam int REG_WORDS = 16;
  localparam int REG_IW    = $clog2(REG_WORDS);  // word index from offset[5:2]

  localparam logic [SYS_DW-1:0] ID_WORD = 32'h5053_4231;

  // ack wait
  localparam int ACK_TIMEOUT = 16;
  localparam int TMR_W       = $clog2(ACK_TIMEOUT + 1);

  // bridge fsm states
  localparam int              ST_W      = 2;
  localparam logic [ST_W-1:0] ST_IDLE   = 2'd0;
  localparam logic [ST_W-1:0] ST_STROBE = 2'd1;
  localparam logic [ST_W-1:0] ST_WAIT   = 2'd2;
  localparam logic [ST_W-1:0] ST_DONE   = 2'd3;

  // system address, flat word or decoded fields
  typedef struct packed {
    logic [TOP_W-1:0]    top_byte;  // ignored by the slave
    logic [REGION_W-1:0] region;
    logic [OFFSET_W-1:0] offset;
  } sys_addr_fields_t;

  typedef union packed {
    logic [SYS_AW-1:0] addr;
    sys_addr_fields_t  fields;
  } sys_addr_u;

endpackage

/* logic/ps_sys_bridge.sv */
////////////////////////////////////////
// apb to system bus bridge, top level
// fsm, ack timer, request latch, slave
////////////////////////////////////////

`timescale 1ns/1ns

module ps_sys_bridge (
  input  logic                          clk,
  input  logic                          reset_i,
  // apb completer
  input  logic                          psel_i,
  input  logic                          penable_i,
  input  logic                          pwrite_i,
  input  logic [ps_bus_pkg::SYS_AW-1:0] paddr_i,
  input  logic [ps_bus_pkg::SYS_DW-1:0] pwdata_i,
  input  logic [ps_bus_pkg::SYS_SW-1:0] pstrb_i,
  output logic                          pready_o,
  output logic [ps_bus_pkg::SYS_DW-1:0] prdata_o,
  output logic                          pslverr_o
);

  import ps_bus_pkg::*;

  // fsm control
  logic              capture;
  logic              timer_start;
  logic              timer_stop;
  logic              timeout;
  // system bus
  sys_addr_u         sys_addr;
  logic [SYS_DW-1:0] sys_wdata;
  logic [SYS_SW-1:0] sys_sel;
  logic              sys_wen;
  logic              sys_ren;
  logic [SYS_DW-1:0] sys_rdata;
  logic              sys_err;
  logic              sys_ack;

  ////////////////////////////////////////
  // bridge
  ////////////////////////////////////////

  apb_sys_fsm i_fsm (
    .clk           (clk        ),
    .reset_i       (reset_i    ),
    .psel_i        (psel_i     ),
    .penable_i     (penable_i  ),
    .pwrite_i      (pwrite_i   ),
    .sys_ack_i     (sys_ack    ),
    .sys_err_i     (sys_err    ),
    .timeout_i     (timeout    ),
    .capture_o     (capture    ),
    .sys_wen_o     (sys_wen    ),
    .sys_ren_o     (sys_ren    ),
    .timer_start_o (timer_start),
    .timer_stop_o  (timer_stop ),
    .pready_o      (pready_o   ),
    .pslverr_o     (pslverr_o  )
  );

  ack_timer i_timer (
    .clk       (clk        ),
    .reset_i   (reset_i    ),
    .start_i   (timer_start),
    .stop_i    (timer_stop ),
    .timeout_o (timeout    )
  );

  sys_req_latch i_latch (
    .clk         (clk      ),
    .reset_i     (reset_i  ),
    .capture_i   (capture  ),
    .pwrite_i    (pwrite_i ),
    .paddr_i     (paddr_i  ),
    .pwdata_i    (pwdata_i ),
    .pstrb_i     (pstrb_i  ),
    .sys_ack_i   (sys_ack  ),
    .sys_rdata_i (sys_rdata),
    .sys_err_i   (sys_err  ),
    .timeout_i   (timeout  ),
    .sys_addr_o  (sys_addr ),
    .sys_wdata_o (sys_wdata),
    .sys_sel_o   (sys_sel  ),
    .prdata_o    (prdata_o )
  );

  ////////////////////////////////////////
  // system bus slave
  ////////////////////////////////////////

  sys_regs i_regs (
    .clk         (clk      ),
    .reset_i     (reset_i  ),
    .sys_addr_i  (sys_addr ),
    .sys_wdata_i (sys_wdata),
    .sys_sel_i   (sys_sel  ),
    .sys_wen_i   (sys_wen  ),
    .sys_ren_i   (sys_ren  ),
    .sys_rdata_o (sys_rdata),
    .sys_err_o   (sys_err  ),
    .sys_ack_o   (sys_ack  )
  );

endmodule

/* logic/sys_regs.sv */
////////////////////////////////////////
// system bus slave
// region 0 byte writable register file
// region 1 read only id word
////////////////////////////////////////

`timescale 1ns/1ns

module sys_regs (
  input  logic                          clk,
  input  logic                          reset_i,
  input  ps_bus_pkg::sys_addr_u         sys_addr_i,
  input  logic [ps_bus_pkg::SYS_DW-1:0] sys_wdata_i,
  input  logic [ps_bus_pkg::SYS_SW-1:0] sys_sel_i,
  input  logic                          sys_wen_i,
  input  logic                          sys_ren_i,
  output logic [ps_bus_pkg::SYS_DW-1:0] sys_rdata_o,
  output logic                          sys_err_o,
  output logic                          sys_ack_o
);

  import ps_bus_pkg::*;

  logic [SYS_DW-1:0] regs [REG_WORDS];  // register file
  logic [REG_IW-1:0] idx;               // word index
  logic              hit_regs;
  logic              hit_id;
  logic              strobe;

  ////////////////////////////////////////
  // region decode
  ////////////////////////////////////////

  assign idx      = sys_addr_i.fields.offset[REG_IW+1:2];  // byte address to word
  assign hit_regs = (sys_addr_i.fields.region == REGION_REGS);
  assign hit_id   = (sys_addr_i.fields.region == REGION_ID);
  assign strobe   = sys_wen_i || sys_ren_i;

  ////////////////////////////////////////
  // handshake
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      sys_ack_o <= 1'b0;
      sys_err_o <= 1'b0;
    end else begin
      // unmapped regions stay silent
      sys_ack_o <= strobe && (hit_regs || hit_id);
      sys_err_o <= sys_wen_i && hit_id;  // write to the id word
    end
  end

  // read word, meaningful only with ack
  always_ff @(posedge clk) begin
    if (sys_ren_i && hit_regs) begin
      sys_rdata_o <= regs[idx];
    end else if (sys_ren_i && hit_id) begin
      sys_rdata_o <= ID_WORD;
    end else begin
      sys_rdata_o <= '0;  // writes return nothing
    end
  end

  ////////////////////////////////////////
  // register file
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      for (int i = 0; i < REG_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (sys_wen_i && hit_regs) begin
      // merge only the selected bytes
      for (int b = 0; b < SYS_SW; b++) begin
        if (sys_sel_i[b]) begin
          regs[idx][8*b +: 8] <= sys_wdata_i[8*b +: 8];
        end
      end
    end
  end

endmodule

/* logic/sys_req_latch.sv */
////////////////////////////////////////
// request hold for the system bus
// response word capture for apb
////////////////////////////////////////

`timescale 1ns/1ns

module sys_req_latch (
  input  logic                          clk,
  input  logic                          reset_i,
  input  logic                          capture_i,    // first access cycle
  input  logic                          pwrite_i,
  input  logic [ps_bus_pkg::SYS_AW-1:0] paddr_i,
  input  logic [ps_bus_pkg::SYS_DW-1:0] pwdata_i,
  input  logic [ps_bus_pkg::SYS_SW-1:0] pstrb_i,
  input  logic                          sys_ack_i,
  input  logic [ps_bus_pkg::SYS_DW-1:0] sys_rdata_i,
  input  logic                          sys_err_i,
  input  logic                          timeout_i,
  output ps_bus_pkg::sys_addr_u         sys_addr_o,
  output logic [ps_bus_pkg::SYS_DW-1:0] sys_wdata_o,
  output logic [ps_bus_pkg::SYS_SW-1:0] sys_sel_o,
  output logic [ps_bus_pkg::SYS_DW-1:0] prdata_o
);

  import ps_bus_pkg::*;

  ////////////////////////////////////////
  // request side
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (capture_i) begin
      sys_addr_o.addr <= paddr_i;   // flat view, slave decodes fields
      sys_wdata_o     <= pwdata_i;
      // reads take the whole word
      sys_sel_o       <= pwrite_i ? pstrb_i : {SYS_SW{1'b1}};
    end
  end

  ////////////////////////////////////////
  // response side
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      prdata_o <= '0;
    end else if (sys_ack_i) begin
      prdata_o <= sys_err_i ? '0 : sys_rdata_i;  // zero on slave error
    end else if (timeout_i) begin
      prdata_o <= '0;                            // nobody answered
    end
  end

endmodule

/* ps_sys_bridge.f */
logic/ps_bus_pkg.sv
logic/ack_timer.sv
logic/sys_req_latch.sv
logic/sys_regs.sv
logic/apb_sys_fsm.sv
logic/ps_sys_bridge.sv
verif/tb_clkgen.sv
verif/ps_sys_bridge_properties.sv
verif/tb_ps_sys_bridge.sv

/* run.sh */
#!/bin/sh
# build the bridge testbench with verilator, run it, look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_ps_sys_bridge -f ps_sys_bridge.f &&
./obj_dir/Vtb_ps_sys_bridge | tee /dev/stderr | grep -F -e '*** PASSED ***' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* verif/ps_sys_bridge_properties.sv */
////////////////////////////////////////
// handshake assertions for the bridge fsm
// apb pready and system bus strobes
////////////////////////////////////////

`timescale 1ns/1ns

module ps_sys_bridge_properties (
  input logic clk,
  input logic reset_i,
  input logic psel_i,
  input logic penable_i,
  input logic sys_wen_i,
  input logic sys_ren_i,
  input logic pready_i
);

  // pready only inside an access phase
  pready_in_access: assert property (
    @(posedge clk) disable iff (reset_i) pready_i |-> (psel_i && penable_i)
  ) else $error("pready_o high outside an apb access phase");

  strobe_exclusive: assert property (
    @(posedge clk) disable iff (reset_i) !(sys_wen_i && sys_ren_i)
  ) else $error("sys_wen and sys_ren high together");

  strobe_one_cycle: assert property (                       // single pulse per transfer
    @(posedge clk) disable iff (reset_i) (sys_wen_i || sys_ren_i) |=> !(sys_wen_i || sys_ren_i)
  ) else $error("system bus strobe longer than one cycle");

  pready_one_cycle: assert property (
    @(posedge clk) disable iff (reset_i) pready_i |=> !pready_i
  ) else $error("pready_o longer than one cycle");

endmodule

bind apb_sys_fsm ps_sys_bridge_properties i_props (
  .clk       (clk      ),
  .reset_i   (reset_i  ),
  .psel_i    (psel_i   ),
  .penable_i (penable_i),
  .sys_wen_i (sys_wen_o),
  .sys_ren_i (sys_ren_o),
  .pready_i  (pready_o )
);

/* verif/tb_clkgen.sv */
////////////////////////////////////////
// testbench clock and reset
////////////////////////////////////////

`timescale 1ns/1ns

module tb_clkgen (
  output logic clk_o,
  output logic reset_o
);

  localparam int HALF_PERIOD  = 4;  // 8 ns clock
  localparam int RESET_CYCLES = 5;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // released on a rising edge, like any other synchronous input
  initial begin
    reset_o = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk_o);
    reset_o <= 1'b0;
  end

endmodule

/* verif/tb_ps_sys_bridge.sv */
////////////////////////////////////////
// testbench for the apb to system bus bridge
// lfsr stimulus, register model, checks
////////////////////////////////////////

`timescale 1ns/1ns

module tb_ps_sys_bridge;

  import ps_bus_pkg::*;

  localparam int QUIET_CYCLES = 10;
  localparam int RESET_CYCLES = 5;
  localparam int N_FULL       = 8;
  localparam int N_STRB       = 12;
  localparam int N_MIX        = 200;
  localparam int N_XFERS      = 2 * N_FULL + 2 * N_STRB + 2 + REG_WORDS + 5 + N_MIX;
  localparam int XFER_CYCLES  = ACK_TIMEOUT + 8;  // worst transfer plus gap
  localparam int WATCHDOG_CYCLES = N_XFERS * XFER_CYCLES + RESET_CYCLES + QUIET_CYCLES;

  logic                clk;
  logic                reset;
  logic                psel;
  logic                penable;
  logic                pwrite;
  logic [SYS_AW-1:0]   paddr;
  logic [SYS_DW-1:0]   pwdata;
  logic [SYS_SW-1:0]   pstrb;
  logic                pready;
  logic [SYS_DW-1:0]   prdata;
  logic                pslverr;
  logic [SYS_DW-1:0]   model_regs [REG_WORDS];  // expected register file
  logic [REG_IW-1:0]   idx_list [N_STRB];       // words written, read back later
  logic [31:0]         lfsr;
  logic [31:0]         r;
  logic [SYS_AW-1:0]   addr;
  logic [SYS_DW-1:0]   wdata;
  logic [REGION_W-1:0] region;
  int                  errors;
  int                  checks;
  int                  xfers;
  int                  tests;
  int                  base_errors;
  int                  base_checks;

  tb_clkgen i_clkgen (
    .clk_o   (clk  ),
    .reset_o (reset)
  );

  ps_sys_bridge i_dut (
    .clk       (clk    ),
    .reset_i   (reset  ),
    .psel_i    (psel   ),
    .penable_i (penable),
    .pwrite_i  (pwrite ),
    .paddr_i   (paddr  ),
    .pwdata_i  (pwdata ),
    .pstrb_i   (pstrb  ),
    .pready_o  (pready ),
    .prdata_o  (prdata ),
    .pslverr_o (pslverr)
  );

  ////////////////////////////////////////
  // random numbers
  ////////////////////////////////////////

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  // random top byte and upper offset, slave ignores both
  task automatic make_addr(input logic [REGION_W-1:0] rg, input logic [REG_IW-1:0] idx,
                           output logic [SYS_AW-1:0] a);
    sys_addr_u   sa;
    logic [31:0] v;
    take_bits(8, v);
    sa.fields.top_byte = v[7:0];
    sa.fields.region   = rg;
    take_bits(14, v);
    sa.fields.offset   = {v[13:0], idx, 2'b00};
    a = sa.addr;
  endtask

  task automatic pick_unmapped(output logic [REGION_W-1:0] rg);
    logic [31:0] v;
    take_bits(REGION_W, v);
    rg = v[REGION_W-1:0];
    if (rg == REGION_REGS || rg == REGION_ID) begin
      rg = rg + 4'd2;  // push off the map
    end
  endtask

  ////////////////////////////////////////
  // model and checks
  ////////////////////////////////////////

  task automatic model_xfer(input logic wr, input logic [SYS_AW-1:0] a,
                            input logic [SYS_DW-1:0] wd, input logic [SYS_SW-1:0] strb,
                            output logic [SYS_DW-1:0] exp_data, output logic exp_err,
                            output int exp_lat);
    sys_addr_u         sa;
    logic [REG_IW-1:0] idx;
    sa.addr  = a;
    idx      = sa.fields.offset[5:2];
    exp_data = '0;
    exp_err  = 1'b0;
    exp_lat  = 3;                       // capture, strobe, ack, pready
    if (sa.fields.region == REGION_REGS) begin
      for (int b = 0; b < SYS_SW; b++) begin
        if (wr && strb[b]) begin
          model_regs[idx][8*b +: 8] = wd[8*b +: 8];
        end
      end
      exp_data = wr ? '0 : model_regs[idx];
    end else if (sa.fields.region == REGION_ID) begin
      exp_err  = wr;                    // id word is read only
      exp_data = wr ? '0 : ID_WORD;
    end else begin
      exp_err = 1'b1;
      exp_lat = ACK_TIMEOUT + 3;        // silent region, wait for the timer
    end
  endtask

  task automatic check_data(input string name, input logic [SYS_DW-1:0] got,
                            input logic [SYS_DW-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_err(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("** Error @ %0t: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_cycles(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("** Error @ %0t: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // apb transfers
  ////////////////////////////////////////

  task automatic idle(input int cycles);
    repeat (cycles) begin
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
    end
  endtask

  task automatic do_xfer(input logic wr, input logic [SYS_AW-1:0] a,
                         input logic [SYS_DW-1:0] wd, input logic [SYS_SW-1:0] strb);
    logic [SYS_DW-1:0] exp_data;
    logic [SYS_DW-1:0] got_data;
    logic              exp_err;
    logic              got_err;
    int                exp_lat;
    int                lat;
    int                n;
    logic [31:0]       gap;
    model_xfer(wr, a, wd, strb, exp_data, exp_err, exp_lat);
    @(posedge clk);
    psel    <= 1'b1;                    // setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= a;
    pwdata  <= wd;
    pstrb   <= strb;
    @(posedge clk);
    penable <= 1'b1;                    // access phase from here
    lat = -1;
    n   = 0;
    while (lat < 0 && n < XFER_CYCLES) begin
      @(negedge clk);                   // mid cycle, outputs settled
      if (pready === 1'b1) begin
        lat      = n;
        got_data = prdata;
        got_err  = pslverr;
      end
      n++;
    end
    xfers++;
    if (lat < 0) begin
      errors++;
      $display("no pready within %0d cycles for paddr %h at %0t", XFER_CYCLES, a, $time);
    end else begin
      check_cycles("pready latency", lat, exp_lat);
      check_err("pslverr_o", got_err, exp_err);
      if (!wr || exp_err) begin
        check_data("prdata_o", got_data, exp_data);
      end
    end
    take_bits(2, gap);
    idle(int'(gap[1:0]));               // 0 to 3 idle cycles
  endtask

  task automatic end_test(input int num, input string name);
    $display("test %0d %s: %0d checks, %0d errors", num, name,
             checks - base_checks, errors - base_errors);
    base_checks = checks;
    base_errors = errors;
    tests++;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  initial begin
    psel        = 1'b0;
    penable     = 1'b0;
    pwrite      = 1'b0;
    paddr       = '0;
    pwdata      = '0;
    pstrb       = '0;
    lfsr        = 32'hc8af;
    errors      = 0;
    checks      = 0;
    xfers       = 0;
    tests       = 0;
    base_errors = 0;
    base_checks = 0;
    for (int i = 0; i < REG_WORDS; i++) begin
      model_regs[i] = '0;               // register file resets to zero
    end
    @(negedge clk);
    while (reset) @(negedge clk);

    repeat (QUIET_CYCLES) begin
      @(negedge clk);
      check_err("pready_o", pready, 1'b0);
      check_err("pslverr_o", pslverr, 1'b0);
    end
    end_test(1, "quiet after reset");

    for (int i = 0; i < N_FULL; i++) begin
      take_bits(REG_IW, r);
      idx_list[i] = r[REG_IW-1:0];
      make_addr(REGION_REGS, idx_list[i], addr);
      take_bits(SYS_DW, wdata);
      do_xfer(1'b1, addr, wdata, '1);
    end
    for (int i = 0; i < N_FULL; i++) begin
      make_addr(REGION_REGS, idx_list[i], addr);
      do_xfer(1'b0, addr, '0, '0);
    end
    end_test(2, "full word write and read");

    for (int i = 0; i < N_STRB; i++) begin
      take_bits(REG_IW + SYS_SW, r);
      idx_list[i] = r[REG_IW+SYS_SW-1:SYS_SW];
      make_addr(REGION_REGS, idx_list[i], addr);
      take_bits(SYS_DW, wdata);
      do_xfer(1'b1, addr, wdata, r[SYS_SW-1:0]);
    end
    for (int i = 0; i < N_STRB; i++) begin
      make_addr(REGION_REGS, idx_list[i], addr);
      do_xfer(1'b0, addr, '0, '0);
    end
    end_test(3, "byte strobe merge");

    make_addr(REGION_ID, '0, addr);
    do_xfer(1'b0, addr, '0, '0);
    take_bits(SYS_DW, wdata);
    make_addr(REGION_ID, '0, addr);
    do_xfer(1'b1, addr, wdata, '1);    // rejected, nothing may change
    for (int i = 0; i < REG_WORDS; i++) begin
      make_addr(REGION_REGS, REG_IW'(i), addr);
      do_xfer(1'b0, addr, '0, '0);
    end
    end_test(4, "id word");

    for (int i = 0; i < 4; i++) begin
      pick_unmapped(region);
      make_addr(region, '0, addr);
      take_bits(SYS_DW, wdata);
      do_xfer(i[0], addr, wdata, i[0] ? '1 : '0);
    end
    make_addr(REGION_REGS, '0, addr);
    do_xfer(1'b0, addr, '0, '0);        // bridge recovers after timeouts
    end_test(5, "unmapped timeout");

    for (int i = 0; i < N_MIX; i++) begin
      take_bits(3, r);
      region = (r[2:0] < 3'd5) ? REGION_REGS : REGION_ID;
      if (r[2:0] == 3'd7) begin
        pick_unmapped(region);
      end
      take_bits(REG_IW, r);
      make_addr(region, r[REG_IW-1:0], addr);
      take_bits(SYS_DW, wdata);
      take_bits(SYS_SW + 1, r);
      do_xfer(r[SYS_SW], addr, wdata, r[SYS_SW] ? r[SYS_SW-1:0] : '0);
    end
    end_test(6, "mixed random");

    idle(1);
    $display("tests %0d, transfers %0d, checks %0d, errors %0d", tests, xfers, checks, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // bound by the transfer count, so a stuck handshake cannot hang the run
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, run did not finish", WATCHDOG_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule
